// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module features_ram \
		logic/feature_loader_pkg.sv logic/beat_fifo_if.sv logic/feature_load_ctrl.sv \
		logic/beat_fifo.sv logic/rgb565_expand.sv logic/features_ram.sv
	verilator --lint-only --timing --assert --top-module tb_features_ram -f features_ram.f

sim:
	verilator --binary --timing --assert --top-module tb_features_ram \
		-Mdir obj_dir -f features_ram.f
	./obj_dir/Vtb_features_ram | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/ddr_read_model.sv
`default_nettype none

module ddr_read_model import feature_loader_pkg::*; (
    input  wire logic                  s_clk,
    input  wire logic                  s_rst,
    input  wire logic                  i_req,
    input  wire logic [ADDR_SIZE-1:0]  i_addr,
    input  wire logic                  i_hold,   // no new grants while high
    output logic      [DATA_WIDTH-1:0] o_data,
    output logic                       o_valid,
    output logic                       o_finish,
    output logic                       o_busy
);

    // memory contents as a function of the beat address
    function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_SIZE-1:0] a);
        return {a ^ 32'hc3a5_5a3c, {a[15:0], a[31:16]} + 32'h0101_0101};
    endfunction

    initial begin
        o_data   = '0;
        o_valid  = 1'b0;
        o_finish = 1'b0;
        o_busy   = 1'b0;
    end

    always begin : serve
        logic [ADDR_SIZE-1:0] base;
        int                   gap;
        @(negedge s_clk);
        if (!s_rst && i_req) begin
            gap = $urandom_range(6, 1);
            repeat (gap) @(negedge s_clk);
            if (!i_hold) begin
                base   = i_addr;  // address latched at grant
                o_busy = 1'b1;
                for (int i = 0; i < IMG_BURST_LENS; i++) begin
                    o_valid = 1'b1;
                    o_data  = mem_word(base + ADDR_SIZE'(i * BEAT_BYTES));
                    @(negedge s_clk);
                end
                o_valid  = 1'b0;
                o_finish = 1'b1;
                @(negedge s_clk);
                o_finish = 1'b0;
                o_busy   = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/features_ram_properties.sv
`default_nettype none

module features_ram_properties import feature_loader_pkg::*; (
    input wire logic                   s_clk,
    input wire logic                   s_rst,
    input wire logic                   req,
    input wire logic                   finish,
    input wire logic                   wr_en,
    input wire logic                   full,
    input wire logic [LEVEL_WIDTH-1:0] level,
    input wire logic [LEVEL_WIDTH-1:0] water_lvl
);

    req_held_a : assert property (@(posedge s_clk) disable iff (s_rst)
        req && !finish |=> req)
        else $error("burst request dropped before finish");

    no_overflow_a : assert property (@(posedge s_clk) disable iff (s_rst)
        wr_en |-> !full)
        else $error("fifo written while full");

    // every buffered beat is still counted in the water level
    water_cover_a : assert property (@(posedge s_clk) disable iff (s_rst)
        level <= water_lvl)
        else $error("fifo holds more beats than the water level counts");

endmodule

bind feature_load_ctrl features_ram_properties props_i (
    .s_clk     (s_clk),
    .s_rst     (s_rst),
    .req       (o_rd_burst_req),
    .finish    (i_rd_burst_finish),
    .wr_en     (fifo.wr_en),
    .full      (fifo.full),
    .level     (fifo.level),
    .water_lvl (water_lvl)
);

`default_nettype wire

// File: dv/tb_features_ram.sv
`default_nettype none

module tb_features_ram import feature_loader_pkg::*; ();

    logic                  s_clk;
    logic                  s_rst;
    logic [DATA_WIDTH-1:0] i_rd_burst_data;
    logic [ADDR_SIZE-1:0]  o_rd_burst_addr;
    logic [LEN_WIDTH-1:0]  o_rd_burst_len;
    logic                  o_rd_burst_req;
    logic                  i_rd_burst_valid;
    logic                  i_rd_burst_finish;
    logic [QUAN_BITS-1:0]  o_feature_data_ch0;
    logic [QUAN_BITS-1:0]  o_feature_data_ch1;
    logic [QUAN_BITS-1:0]  o_feature_data_ch2;
    logic                  o_f_data_valid;
    logic                  i_data_ready;
    logic                  i_load_d_once_done;
    logic                  i_data_load_done;
    logic                  hold;
    logic                  busy;
    logic                  stall;
    logic                  valid_q;
    logic [ADDR_SIZE-1:0]  exp_addr;
    int                    exp_k;
    int                    pix_seen;
    int                    checks;
    int                    errors;

    features_ram dut_i (.*);

    ddr_read_model ddr_i (
        .s_clk (s_clk), .s_rst (s_rst), .i_req (o_rd_burst_req), .i_addr (o_rd_burst_addr),
        .i_hold (hold), .o_data (i_rd_burst_data), .o_valid (i_rd_burst_valid),
        .o_finish (i_rd_burst_finish), .o_busy (busy)
    );

    always #4 s_clk = ~s_clk;

    // channels of pixel k, counted from the image base
    function automatic logic [23:0] expected_pixel(input int k);
        logic [ADDR_SIZE-1:0]  a;
        logic [DATA_WIDTH-1:0] w;
        logic [15:0]           p;
        a = IMG_BASEADDR + ADDR_SIZE'((k / 4) * 8);
        w = {a ^ 32'hc3a5_5a3c, {a[15:0], a[31:16]} + 32'h0101_0101};
        p = w[(k % 4)*16 +: 16];
        return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
    endfunction

    function automatic void check_value(input string name, input logic [31:0] exp_v,
                                        input logic [31:0] got_v);
        checks++;
        assert (exp_v == got_v) else begin
            $display("ERROR %s expected %h got %h", name, exp_v, got_v);
            errors++;
        end
    endfunction

    // outputs only change on clock edges, so the old values are read here
    always @(posedge s_clk) begin : compare
        logic [23:0] e;
        if (!s_rst && o_f_data_valid) begin
            e = expected_pixel(exp_k);
            check_value("o_feature_data_ch0", e[23:16], o_feature_data_ch0);
            check_value("o_feature_data_ch1", e[15:8], o_feature_data_ch1);
            check_value("o_feature_data_ch2", e[7:0], o_feature_data_ch2);
            exp_k++;
            pix_seen++;
        end
        if (i_data_load_done || i_load_d_once_done) exp_k = 0;
    end

    always @(posedge s_clk) begin
        if (s_rst) begin
            valid_q  <= 1'b0;
            exp_addr <= IMG_BASEADDR;
        end else begin
            valid_q <= i_rd_burst_valid;
            if (i_rd_burst_valid && !valid_q) begin  // first beat of a burst
                check_value("o_rd_burst_addr", exp_addr, o_rd_burst_addr);
                check_value("o_rd_burst_len", IMG_BURST_LENS, o_rd_burst_len);
                check_value("fifo_level_ok", 1, dut_i.fifo_bus.level <= REQ_THRESHOLD);
            end
            if (i_data_load_done || i_load_d_once_done) exp_addr <= IMG_BASEADDR;
            else if (i_rd_burst_finish) exp_addr <= exp_addr + ADDR_SIZE'(BURST_BYTES);
        end
    end

    always @(negedge s_clk) begin
        i_data_ready = stall ? 1'b0 : (($urandom % 4) != 0);
    end

    task automatic wait_pixels(input int n, input int limit);
        int t;
        t = 0;
        while (pix_seen < n && t < limit) begin
            @(negedge s_clk);
            t++;
        end
        if (pix_seen < n) begin
            $display("timeout: pixel stream stopped at %0d of %0d pixels", pix_seen, n);
            errors++;
        end
    endtask

    task automatic restart(input bit once);
        int t;
        t = 0;
        @(posedge s_clk) hold = 1'b1;
        @(negedge s_clk);
        while (busy && t < 100) begin
            @(negedge s_clk);
            t++;
        end
        if (busy) begin
            $display("timeout: DDR burst never finished before restart");
            errors++;
        end
        if (once) i_load_d_once_done = 1'b1;
        else i_data_load_done = 1'b1;
        @(negedge s_clk);
        i_load_d_once_done = 1'b0;
        i_data_load_done   = 1'b0;
        @(posedge s_clk) hold = 1'b0;
    endtask

    initial begin
        void'($urandom(46641));
        {s_clk, hold, stall, i_data_ready} = '0;
        {i_load_d_once_done, i_data_load_done} = '0;
        {exp_k, pix_seen, checks, errors} = '0;
        s_rst = 1'b1;
        repeat (3) @(posedge s_clk);
        @(negedge s_clk) s_rst = 1'b0;
        check_value("o_rd_burst_req", 0, o_rd_burst_req);
        check_value("o_f_data_valid", 0, o_f_data_valid);
        check_value("o_rd_burst_addr", IMG_BASEADDR, o_rd_burst_addr);
        wait_pixels(256, 20000);
        @(posedge s_clk) stall = 1'b1;  // long back-pressure, fifo fills up
        repeat (200) @(negedge s_clk);
        check_value("o_rd_burst_req", 0, o_rd_burst_req);
        @(posedge s_clk) stall = 1'b0;
        wait_pixels(pix_seen + 256, 20000);
        restart(1'b0);
        wait_pixels(pix_seen + 300, 20000);
        restart(1'b1);
        wait_pixels(pix_seen + 200, 20000);
        repeat (4) @(negedge s_clk);
        $display("checks=%0d errors=%0d pixels=%0d", checks, errors, pix_seen);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: features_ram.f
logic/feature_loader_pkg.sv
logic/beat_fifo_if.sv
logic/feature_load_ctrl.sv
logic/beat_fifo.sv
logic/rgb565_expand.sv
logic/features_ram.sv
dv/ddr_read_model.sv
dv/features_ram_properties.sv
dv/tb_features_ram.sv

// File: logic/beat_fifo.sv
`default_nettype none

module beat_fifo import feature_loader_pkg::*; (
    input  wire logic s_clk,
    input  wire logic s_rst,
    beat_fifo_if.fifo port
);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH_BEATS];

    logic [FIFO_AW:0]    wr_ptr;  // extra bit tells full from empty
    logic [FIFO_AW:0]    rd_ptr;
    logic [HSEL_W-1:0]   hsel;    // halfword within head beat
    logic                wr_ok;
    logic                rd_ok;
    logic                last_half;
    logic [DATA_WIDTH-1:0] head;

    assign wr_ok     = port.wr_en & ~port.full;
    assign rd_ok     = port.rd_en & ~port.empty;
    assign last_half = (hsel == HSEL_W'(PIX_PER_BEAT - 1));

    assign port.level = wr_ptr - rd_ptr;
    assign port.empty = (wr_ptr == rd_ptr);
    assign port.full  = (port.level == LEVEL_WIDTH'(FIFO_DEPTH_BEATS));

    // first word fall through, low halfword first
    assign head         = mem[rd_ptr[FIFO_AW-1:0]];
    assign port.rd_data = head[hsel*PIX_BITS +: PIX_BITS];

    always_ff @(posedge s_clk) begin
        if (wr_ok) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= port.wr_data;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
        end else if (port.flush) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_ptr <= '0;
            hsel   <= '0;
        end else if (port.flush) begin
            rd_ptr <= '0;
            hsel   <= '0;
        end else if (rd_ok) begin
            hsel <= hsel + 1'b1;  // wraps after the fourth pixel
            if (last_half) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/beat_fifo_if.sv
`default_nettype none

interface beat_fifo_if import feature_loader_pkg::*; ();

    logic                   wr_en;
    logic [DATA_WIDTH-1:0]  wr_data;
    logic                   rd_en;
    logic                   flush;
    logic [PIX_BITS-1:0]    rd_data;  // fall-through halfword
    logic [LEVEL_WIDTH-1:0] level;    // beats held
    logic                   empty;
    logic                   full;

    modport fifo (
        input  wr_en, wr_data, rd_en, flush,
        output rd_data, level, empty, full
    );

    modport ctrl (
        input  empty, full, level, wr_en,
        output rd_en, flush
    );

    modport sink (
        input  rd_data, rd_en
    );

endinterface

`default_nettype wire

// File: logic/feature_load_ctrl.sv
`default_nettype none

module feature_load_ctrl import feature_loader_pkg::*; (
    input  wire logic                 s_clk,
    input  wire logic                 s_rst,
    input  wire logic                 i_rd_burst_valid,
    input  wire logic                 i_rd_burst_finish,
    input  wire logic                 i_data_ready,
    input  wire logic                 i_load_d_once_done,
    input  wire logic                 i_data_load_done,
    output logic [ADDR_SIZE-1:0]      o_rd_burst_addr,
    output logic                      o_rd_burst_req,
    beat_fifo_if.ctrl                 fifo
);

    logic                   restart;
    logic                   valid_d0;
    logic                   valid_rise;
    logic                   rd_fire;
    logic [LEVEL_WIDTH-1:0] water_lvl;
    logic [HSEL_W-1:0]      pix_cnt;  // pixel within current beat

    assign restart    = i_data_load_done | i_load_d_once_done;
    assign valid_rise = i_rd_burst_valid & ~valid_d0;

    // ddr writes win over reads
    assign rd_fire = ~fifo.empty & i_data_ready & ~i_rd_burst_valid & ~restart;

    assign fifo.rd_en = rd_fire;
    assign fifo.flush = restart;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_rd_burst_addr <= IMG_BASEADDR;
        end else if (restart) begin
            o_rd_burst_addr <= IMG_BASEADDR;
        end else if (i_rd_burst_finish) begin
            o_rd_burst_addr <= o_rd_burst_addr + ADDR_SIZE'(BURST_BYTES);
        end
    end

    // level request, held until the burst finishes
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_rd_burst_req <= 1'b0;
        end else if (i_rd_burst_finish) begin
            o_rd_burst_req <= 1'b0;
        end else if (water_lvl < LEVEL_WIDTH'(REQ_THRESHOLD)) begin
            o_rd_burst_req <= 1'b1;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            valid_d0 <= 1'b0;
        end else begin
            valid_d0 <= i_rd_burst_valid;
        end
    end

    // whole burst counted at its first beat
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            water_lvl <= '0;
        end else if (restart) begin
            water_lvl <= '0;
        end else if (valid_rise) begin
            water_lvl <= water_lvl + LEVEL_WIDTH'(IMG_BURST_LENS);
        end else if (rd_fire && pix_cnt == HSEL_W'(PIX_PER_BEAT - 1)) begin
            water_lvl <= water_lvl - 1'b1;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pix_cnt <= '0;
        end else if (restart) begin
            pix_cnt <= '0;
        end else if (rd_fire) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/feature_loader_pkg.sv
`default_nettype none

package feature_loader_pkg;

    localparam int DATA_WIDTH       = 64;  // ddr beat
    localparam int ADDR_SIZE        = 32;  // byte address
    localparam int LEN_WIDTH        = 8;
    localparam int QUAN_BITS        = 8;   // one output channel
    localparam int PIX_BITS         = 16;
    localparam int PIX_PER_BEAT     = DATA_WIDTH / PIX_BITS;
    localparam int IMG_BURST_LENS   = 8;   // beats per burst
    localparam int FIFO_DEPTH_BEATS = 32;

    localparam logic [ADDR_SIZE-1:0] IMG_BASEADDR = 32'h1000_0000;

    localparam int BEAT_BYTES    = DATA_WIDTH / 8;
    localparam int BURST_BYTES   = IMG_BURST_LENS * BEAT_BYTES;  // 64
    localparam int FIFO_AW       = $clog2(FIFO_DEPTH_BEATS);
    localparam int LEVEL_WIDTH   = FIFO_AW + 1;  // holds 0 .. depth
    localparam int HSEL_W        = $clog2(PIX_PER_BEAT);
    localparam int REQ_THRESHOLD = FIFO_DEPTH_BEATS - IMG_BURST_LENS;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // same halfword, raw or split into colour fields
    typedef union packed {
        logic [PIX_BITS-1:0] raw;
        rgb565_t             rgb;
    } pixel_word_u;

endpackage

`default_nettype wire

// File: logic/features_ram.sv
`default_nettype none

module features_ram import feature_loader_pkg::*; (
    input  wire logic                  s_clk,
    input  wire logic                  s_rst,
    // ddr read port
    input  wire logic [DATA_WIDTH-1:0] i_rd_burst_data,
    output logic [ADDR_SIZE-1:0]       o_rd_burst_addr,
    output logic [LEN_WIDTH-1:0]       o_rd_burst_len,
    output logic                       o_rd_burst_req,
    input  wire logic                  i_rd_burst_valid,
    input  wire logic                  i_rd_burst_finish,
    // toward conv layer 1
    output logic [QUAN_BITS-1:0]       o_feature_data_ch0,
    output logic [QUAN_BITS-1:0]       o_feature_data_ch1,
    output logic [QUAN_BITS-1:0]       o_feature_data_ch2,
    output logic                       o_f_data_valid,
    input  wire logic                  i_data_ready,
    input  wire logic                  i_load_d_once_done,
    input  wire logic                  i_data_load_done
);

    beat_fifo_if fifo_bus ();

    assign fifo_bus.wr_en   = i_rd_burst_valid;
    assign fifo_bus.wr_data = i_rd_burst_data;
    assign o_rd_burst_len   = LEN_WIDTH'(IMG_BURST_LENS);

    feature_load_ctrl ctrl_i (
        .s_clk              (s_clk),
        .s_rst              (s_rst),
        .i_rd_burst_valid   (i_rd_burst_valid),
        .i_rd_burst_finish  (i_rd_burst_finish),
        .i_data_ready       (i_data_ready),
        .i_load_d_once_done (i_load_d_once_done),
        .i_data_load_done   (i_data_load_done),
        .o_rd_burst_addr    (o_rd_burst_addr),
        .o_rd_burst_req     (o_rd_burst_req),
        .fifo               (fifo_bus.ctrl)
    );

    beat_fifo fifo_i (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .port  (fifo_bus.fifo)
    );

    rgb565_expand expand_i (
        .s_clk              (s_clk),
        .s_rst              (s_rst),
        .pix                (fifo_bus.sink),
        .o_feature_data_ch0 (o_feature_data_ch0),
        .o_feature_data_ch1 (o_feature_data_ch1),
        .o_feature_data_ch2 (o_feature_data_ch2),
        .o_f_data_valid     (o_f_data_valid)
    );

endmodule

`default_nettype wire

// File: logic/rgb565_expand.sv
`default_nettype none

module rgb565_expand import feature_loader_pkg::*; (
    input  wire logic             s_clk,
    input  wire logic             s_rst,
    beat_fifo_if.sink             pix,
    output logic [QUAN_BITS-1:0]  o_feature_data_ch0,
    output logic [QUAN_BITS-1:0]  o_feature_data_ch1,
    output logic [QUAN_BITS-1:0]  o_feature_data_ch2,
    output logic                  o_f_data_valid
);

    pixel_word_u pix_w;

    assign pix_w.raw = pix.rd_data;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_f_data_valid <= 1'b0;
        end else begin
            o_f_data_valid <= pix.rd_en;  // one cycle after the read
        end
    end

    // top bits repeated into the low bits, so full scale maps to 8'hff
    always_ff @(posedge s_clk) begin
        if (pix.rd_en) begin
            o_feature_data_ch0 <= {pix_w.rgb.red,   pix_w.rgb.red[4:2]};
            o_feature_data_ch1 <= {pix_w.rgb.green, pix_w.rgb.green[5:4]};
            o_feature_data_ch2 <= {pix_w.rgb.blue,  pix_w.rgb.blue[4:2]};
        end
    end

endmodule

`default_nettype wire
